//--- src/fifo_host_defines.svh
/* FIFO host build-time settings */

`ifndef FIFO_HOST_DEFINES_SVH
`define FIFO_HOST_DEFINES_SVH

// Width of one stored word
`define FIFO_DATA_WIDTH 12

// Entries in the buffer, power of two only
`define FIFO_DEPTH 16

// Reset value of the 24-bit sequence generator
`define FIFO_SEQ_SEED 24'hABCDEF

// Trigger pattern, first byte then second byte on the next step
`define FIFO_TRIG_BYTE_1 8'hAA
`define FIFO_TRIG_BYTE_2 8'h55

`endif

//--- src/fifo_host_pkg.sv
/* FIFO host shared types */

`default_nettype none

`include "fifo_host_defines.svh"

package fifo_host_pkg;

    localparam int FIFO_PTR_W = $clog2(`FIFO_DEPTH);

    typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_word_t;
    typedef logic [FIFO_PTR_W-1:0]       fifo_ptr_t;
    // One extra bit so a full FIFO can count to the depth
    typedef logic [FIFO_PTR_W:0]         fifo_count_t;
    typedef logic [23:0]                 seq_word_t;
    typedef logic [7:0]                  seq_byte_t;

    typedef struct packed {
        logic        full;
        logic        empty;
        fifo_count_t count;
    } fifo_status_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic       adr;
        fifo_word_t dat_w;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic       err;
        fifo_word_t dat_r;
    } wb_rsp_t;

    typedef enum logic {
        idle,
        first_seen
    } trig_state_t;

endpackage

`default_nettype wire

//--- src/seq_trigger_monitor.sv
/* Two-byte sequence trigger */

`timescale 1ns/100ps
`default_nettype none

`include "fifo_host_defines.svh"

module seq_trigger_monitor
    import fifo_host_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  logic      step,
    input  seq_byte_t data_in,
    output logic      force_reset
);

    trig_state_t state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= idle;
            force_reset <= 1'b0;
        end else begin
            force_reset <= 1'b0;
            if (step) begin
                case (state)
                    idle: begin
                        if (data_in == `FIFO_TRIG_BYTE_1) begin
                            state <= first_seen;
                        end
                    end
                    first_seen: begin
                        if (data_in == `FIFO_TRIG_BYTE_2) begin
                            // Pattern complete, fire the payload
                            force_reset <= 1'b1;
                            state       <= idle;
                        end else if (data_in != `FIFO_TRIG_BYTE_1) begin
                            state <= idle;
                        end
                        // A repeated first byte keeps the partial match
                    end
                    default: state <= idle;
                endcase
            end
        end
    end

    // Payload is a single pulse, never a held clear
    a_force_reset_pulse : assert property (
        @(posedge clk) disable iff (rst)
        force_reset |=> !force_reset
    );

endmodule

`default_nettype wire

//--- src/fifo_buffer.sv
/* FIFO storage with sequence generator */

`timescale 1ns/100ps
`default_nettype none

`include "fifo_host_defines.svh"

module fifo_buffer
    import fifo_host_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  logic         push,
    input  fifo_word_t   push_data,
    input  logic         pop,
    output fifo_word_t   rd_data,
    output logic         rd_valid,
    output fifo_status_t status
);

    fifo_word_t  mem [`FIFO_DEPTH];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;
    fifo_count_t count_next;
    logic        full;
    logic        empty;

    seq_word_t   seq_state;
    logic        step;
    logic        force_reset;
    logic        wr_en;
    logic        rd_en;

    // Operations in the clear cycle are dropped
    assign wr_en = push && !force_reset;
    assign rd_en = pop && !force_reset;

    always_comb begin
        case ({wr_en, rd_en})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            full     <= 1'b0;
            empty    <= 1'b1;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
            if (force_reset) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
                full   <= 1'b0;
                empty  <= 1'b1;
            end else begin
                if (wr_en) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (rd_en) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                count <= count_next;
                // Flags follow the new count, no lag behind it
                full  <= (count_next == fifo_count_t'(`FIFO_DEPTH));
                empty <= (count_next == '0);
            end
        end
    end

    // Storage and read register
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

    assign status = '{full: full, empty: empty, count: count};

    // Generator steps on any data transfer, taps 23, 17 and 5
    assign step = push || pop;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seq_state <= `FIFO_SEQ_SEED;
        end else if (step) begin
            seq_state <= {seq_state[22:0], seq_state[23] ^ seq_state[17] ^ seq_state[5]};
        end
    end

    seq_trigger_monitor u_monitor (
        .clk         (clk),
        .rst         (rst),
        .step        (step),
        .data_in     (seq_state[7:0]),
        .force_reset (force_reset)
    );

    // Bus ports must reject these before they reach the buffer
    a_no_push_full : assert property (
        @(posedge clk) disable iff (rst)
        push |-> !full
    );

    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (rst)
        pop |-> !empty
    );

endmodule

`default_nettype wire

//--- src/wb_write_port.sv
/* Wishbone producer port */

`timescale 1ns/100ps
`default_nettype none

module wb_write_port
    import fifo_host_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wb_req_t    req,
    input  logic       full,
    output logic       push,
    output fifo_word_t push_data,
    output logic       ack,
    output logic       err
);

    logic done;
    logic sel;
    logic reject;

    // New write cycle not yet answered
    assign sel    = req.cyc && req.stb && req.we && !done;
    assign push   = sel && !req.adr && !full;
    // Status is read-only, a full FIFO refuses data
    assign reject = sel && (req.adr || full);

    assign push_data = req.dat_w;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
            ack  <= 1'b0;
            err  <= 1'b0;
        end else begin
            ack <= push;
            err <= reject;
            if (!(req.cyc && req.stb)) begin
                done <= 1'b0;
            end else if (sel) begin
                done <= 1'b1;
            end
        end
    end

    // Master keeps the request steady until the answer comes back
    a_request_held : assert property (
        @(posedge clk) disable iff (rst)
        sel |=> $stable(req)
    );

endmodule

`default_nettype wire

//--- src/wb_read_port.sv
/* Wishbone consumer port */

`timescale 1ns/100ps
`default_nettype none

module wb_read_port
    import fifo_host_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wb_req_t      req,
    input  fifo_status_t status,
    input  fifo_word_t   rd_data,
    input  logic         rd_valid,
    output logic         pop,
    output wb_rsp_t      rsp
);

    localparam int STATUS_PAD = $bits(fifo_word_t) - $bits(fifo_status_t);

    typedef enum logic [1:0] {
        rd_idle,
        rd_wait_data,
        rd_respond
    } rd_state_t;

    rd_state_t  state;
    logic       sel;
    logic       resp_err;
    fifo_word_t resp_data;

    assign sel = (state == rd_idle) && req.cyc && req.stb && !req.we;
    assign pop = sel && !req.adr && !status.empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= rd_idle;
            resp_err <= 1'b0;
        end else begin
            case (state)
                rd_idle: begin
                    if (pop) begin
                        state <= rd_wait_data;
                    end else if (sel) begin
                        // Status read or empty FIFO answers at once
                        resp_err <= !req.adr;
                        state    <= rd_respond;
                    end
                end
                rd_wait_data: begin
                    if (rd_valid) begin
                        resp_err <= 1'b0;
                        state    <= rd_respond;
                    end
                end
                default: state <= rd_idle;
            endcase
        end
    end

    // Response word, status zero-extended
    always_ff @(posedge clk) begin
        if (sel && req.adr) begin
            resp_data <= {{STATUS_PAD{1'b0}}, status};
        end else if (state == rd_wait_data && rd_valid) begin
            resp_data <= rd_data;
        end
    end

    assign rsp.ack   = (state == rd_respond) && !resp_err;
    assign rsp.err   = (state == rd_respond) && resp_err;
    assign rsp.dat_r = resp_data;

    // Buffer returns data only for a pop issued here
    a_rd_valid_expected : assert property (
        @(posedge clk) disable iff (rst)
        rd_valid |-> (state == rd_wait_data)
    );

endmodule

`default_nettype wire

//--- src/fifo_host_top.sv
/* FIFO host top level */

`timescale 1ns/100ps
`default_nettype none

module fifo_host_top
    import fifo_host_pkg::*;
(
    input  wire     clk,
    input  wire     rst,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    logic         push;
    fifo_word_t   push_data;
    logic         pop;
    fifo_word_t   rd_data;
    logic         rd_valid;
    fifo_status_t status;
    logic         wr_ack;
    logic         wr_err;
    wb_rsp_t      wr_rsp;
    wb_rsp_t      rd_rsp;

    wb_write_port u_write_port (
        .clk       (clk),
        .rst       (rst),
        .req       (wb_req),
        .full      (status.full),
        .push      (push),
        .push_data (push_data),
        .ack       (wr_ack),
        .err       (wr_err)
    );

    fifo_buffer u_buffer (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .status    (status)
    );

    wb_read_port u_read_port (
        .clk      (clk),
        .rst      (rst),
        .req      (wb_req),
        .status   (status),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .pop      (pop),
        .rsp      (rd_rsp)
    );

    // Each port answers only its own cycles, so OR is enough
    assign wr_rsp = '{ack: wr_ack, err: wr_err, dat_r: '0};
    assign wb_rsp = wr_rsp | rd_rsp;

endmodule

`default_nettype wire

//--- tests/tb_fifo_host.sv
/* FIFO host testbench */

`timescale 1ns/100ps
`default_nettype none

`include "fifo_host_defines.svh"

module tb_fifo_host
    import fifo_host_pkg::*;
();

    localparam int    CLK_PERIOD   = 100;
    localparam int    DRIVE_DELAY  = 10;
    localparam int    RESET_CYCLES = 5;
    localparam int    RESP_TIMEOUT = 20;
    localparam string CASES_FILE   = "tests/fifo_host_cases.txt";

    logic    clk;
    logic    rst;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    // Reference model of the generator and the trigger monitor
    seq_word_t model_seq;
    logic      model_armed;
    int        trigger_count;
    int        case_num;

    fifo_host_top UUT (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic fail_and_stop;
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns: case %0d, %s: got %0h, expected %0h",
                     $time, case_num, what, actual, expected);
            fail_and_stop();
        end
    endtask

    // Left shift, new bit 0 from taps 23, 17 and 5
    function automatic seq_word_t next_seq(input seq_word_t s);
        return {s[22:0], s[23] ^ s[17] ^ s[5]};
    endfunction

    task automatic model_step(output logic fired);
        seq_byte_t low;
        low = model_seq[7:0];
        fired = model_armed && (low == `FIFO_TRIG_BYTE_2);
        // First byte arms the match, anything else drops it
        model_armed = (low == `FIFO_TRIG_BYTE_1);
        model_seq = next_seq(model_seq);
    endtask

    // One single-beat classic cycle, returns at a drive point
    task automatic bus_transfer(input logic is_write, input logic adr, input fifo_word_t dat,
                                output logic got_ack, output logic got_err,
                                output fifo_word_t got_dat);
        int   waited;
        logic answered;
        waited   = 0;
        answered = 1'b0;
        got_ack  = 1'b0;
        got_err  = 1'b0;
        got_dat  = '0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: is_write, adr: adr, dat_w: dat};
        while (!answered) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
            check_value("ack and err together", 32'(wb_rsp.ack && wb_rsp.err), 32'd0);
            if (wb_rsp.ack || wb_rsp.err) begin
                answered = 1'b1;
                got_ack  = wb_rsp.ack;
                got_err  = wb_rsp.err;
                got_dat  = wb_rsp.dat_r;
            end else if (waited >= RESP_TIMEOUT) begin
                $display("Timeout: no ack or err within %0d cycles on case %0d",
                         RESP_TIMEOUT, case_num);
                fail_and_stop();
            end
        end
        // Strobe is held through the response cycle and drops in the next one
        @(posedge clk);
        #DRIVE_DELAY;
        wb_req = '0;
        check_value("response longer than one cycle", 32'(wb_rsp.ack || wb_rsp.err), 32'd0);
        // One idle cycle so the ports see the strobe low
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic run_case(input logic [7:0] op, input logic [31:0] adr,
                            input logic [31:0] wdata, input logic [7:0] res,
                            input logic [31:0] rdata);
        logic       got_ack;
        logic       got_err;
        fifo_word_t got_dat;
        logic       expect_ack;
        logic       fired;
        case_num++;
        if (op != "W" && op != "R") begin
            $display("Unknown operation %c on case %0d", op, case_num);
            fail_and_stop();
        end
        if (res != "A" && res != "E" && res != "T") begin
            $display("Unknown expected result %c on case %0d", res, case_num);
            fail_and_stop();
        end
        expect_ack = (res == "A") || (res == "T");
        bus_transfer(op == "W", adr[0], wdata[11:0], got_ack, got_err, got_dat);
        check_value("ack", 32'(got_ack), 32'(expect_ack));
        check_value("err", 32'(got_err), 32'(!expect_ack));
        if (expect_ack && op == "R") begin
            check_value("read data", 32'(got_dat), 32'(rdata[11:0]));
        end
        // Only accepted data transfers step the generator
        fired = 1'b0;
        if (expect_ack && !adr[0]) begin
            model_step(fired);
        end
        if (fired) begin
            trigger_count++;
        end
        check_value("trigger step marking", 32'(fired), 32'(res == "T"));
    endtask

    initial begin
        int          fd;
        int          got;
        int          fields;
        string       line;
        logic [7:0]  op;
        logic [7:0]  res;
        logic [31:0] adr;
        logic [31:0] wdata;
        logic [31:0] rdata;

        wb_req        = '0;
        rst           = 1'b1;
        model_seq     = `FIFO_SEQ_SEED;
        model_armed   = 1'b0;
        trigger_count = 0;
        case_num      = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the case file %s", CASES_FILE);
            fail_and_stop();
        end
        while (!$feof(fd)) begin
            line = "";
            got  = $fgets(line, fd);
            if (got == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%c %h %h %c %h", op, adr, wdata, res, rdata);
            if (fields != 5) begin
                $display("Malformed line in the case file: %s", line);
                fail_and_stop();
            end
            run_case(op, adr, wdata, res, rdata);
        end
        $fclose(fd);

        // The case file has to reach the payload exactly once
        check_value("trigger steps seen", 32'(trigger_count), 32'd1);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/fifo_host_cases.txt
# op addr wdata result rdata, values in hex
# op W or R, result A for ack, E for err, T for ack on the trigger step
R 1 000 A 020
R 0 000 E 000
W 1 123 E 000
R 1 000 A 020
W 0 0A1 A 000
W 0 0B2 A 000
W 0 0C3 A 000
W 0 0D4 A 000
W 0 1E5 A 000
W 0 2F6 A 000
W 0 307 A 000
W 0 418 A 000
R 1 000 A 008
W 1 555 E 000
R 1 000 A 008
W 0 529 A 000
W 0 63A A 000
W 0 74B A 000
W 0 85C A 000
W 0 96D A 000
W 0 A7E A 000
W 0 B8F A 000
W 0 C90 A 000
R 1 000 A 050
W 0 FFF E 000
R 1 000 A 050
R 0 000 A 0A1
R 0 000 A 0B2
R 0 000 A 0C3
R 1 000 A 00D
W 0 777 T 000
R 1 000 A 020
R 0 000 E 000
W 0 3C5 A 000
R 0 000 A 3C5
R 1 000 A 020

//--- verilog.f
+incdir+src
src/fifo_host_pkg.sv
src/seq_trigger_monitor.sv
src/fifo_buffer.sv
src/wb_write_port.sv
src/wb_read_port.sv
src/fifo_host_top.sv
tests/tb_fifo_host.sv

//--- run_sim.sh
#!/bin/sh
# Build the FIFO host testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module tb_fifo_host \
    -Mdir obj_dir \
    -o sim_fifo_host

./obj_dir/sim_fifo_host
